/* common/tank_params.svh */
// grid size, coordinate width, enemy count and kill counter width
`ifndef TANK_PARAMS_SVH
`define TANK_PARAMS_SVH

// ------------------------------
// playfield
// ------------------------------
`define TANK_COORD_W   5    // holds 0..20
`define TANK_X_MAX     16   // last column
`define TANK_Y_MAX     20   // last row

// ------------------------------
// enemies and scoring
// ------------------------------
`define TANK_ENEMY_CNT 4    // one per corner
`define TANK_KILL_W    8    // saturating kill counter

`endif

/* common/tank_geom_pkg.sv */
// coordinate, position, heading and relative-direction types, grid step helpers
`default_nettype none

`include "tank_params.svh"

package tank_geom_pkg;

	typedef logic [`TANK_COORD_W-1:0] coord_t;

	typedef struct packed {
		coord_t x;  // column, 0 at the left
		coord_t y;  // row, 0 at the top
	} pos_t;

	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,  // y decreasing
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} tank_dir_t;

	// one 3-bit word, meaning of the low bits set by is_line
	typedef union packed {
		struct packed {
			logic is_line;  // 0 here
			logic left;     // enemy left of player
			logic above;    // enemy above player
		} quad;
		struct packed {
			logic is_line;  // 1 here
			logic vert;     // same column, line runs vertically
			logic far;      // enemy coordinate is the greater one
		} line;
	} rel_dir_u;

	typedef struct packed {
		rel_dir_u rel;
		coord_t   h_dis;  // |dx|
		coord_t   v_dis;  // |dy|
		logic     equal;  // same cell
	} relpos_t;

	// true when one cell toward d stays on the grid
	function automatic logic step_ok(input pos_t p, input tank_dir_t d);
		case (d)
			DIR_UP:   return p.y != '0;
			DIR_DOWN: return p.y < coord_t'(`TANK_Y_MAX);
			DIR_LEFT: return p.x != '0;
			default:  return p.x < coord_t'(`TANK_X_MAX);
		endcase
	endfunction

	// neighbour cell toward d, no edge check
	function automatic pos_t step_pos(input pos_t p, input tank_dir_t d);
		pos_t n;
		n = p;
		case (d)
			DIR_UP:   n.y = p.y - coord_t'(1);
			DIR_DOWN: n.y = p.y + coord_t'(1);
			DIR_LEFT: n.x = p.x - coord_t'(1);
			default:  n.x = p.x + coord_t'(1);
		endcase
		return n;
	endfunction

endpackage

`default_nettype wire

/* common/tank_ctrl_pkg.sv */
// player command, bullet and enemy status structs
`default_nettype none

package tank_ctrl_pkg;

	import tank_geom_pkg::*;

	// ------------------------------
	// player side
	// ------------------------------
	typedef struct packed {
		logic      move;      // step this tick
		tank_dir_t move_dir;  // heading of the step
		logic      fire;      // launch if no bullet in flight
	} player_cmd_t;

	typedef struct packed {
		logic      active;  // in flight
		pos_t      pos;
		tank_dir_t dir;     // travel direction
	} bullet_t;

	// ------------------------------
	// enemy side
	// ------------------------------
	typedef struct packed {
		logic      alive;
		pos_t      pos;
		tank_dir_t dir;   // last attempted heading
		logic      fire;  // lined up with the player
	} enemy_status_t;

endpackage

`default_nettype wire

/* logic/player_tank.sv */
// player tank movement and single bullet launch, flight and retirement
`default_nettype none
`timescale 1ns/100ps

`include "tank_params.svh"

module player_tank
	import tank_geom_pkg::*, tank_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        tick,        // one game step
	input  player_cmd_t cmd,
	input  logic        bullet_hit,  // some enemy died last tick
	output pos_t        player_pos,
	output bullet_t     bullet
);

	localparam coord_t START_X = coord_t'(`TANK_X_MAX / 2);  // bottom middle
	localparam coord_t START_Y = coord_t'(`TANK_Y_MAX);

	tank_dir_t heading;  // last commanded direction, used for launch

	// ------------------------------
	// tank movement
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			player_pos <= '{x: START_X, y: START_Y};
			heading    <= DIR_UP;
		end
		else if (tick && cmd.move)
		begin
			heading <= cmd.move_dir;  // turn even when blocked
			if (step_ok(player_pos, cmd.move_dir))
				player_pos <= step_pos(player_pos, cmd.move_dir);
		end
	end

	// ------------------------------
	// bullet
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
			bullet <= '0;
		else if (bullet_hit)
			bullet.active <= 1'b0;  // kill pulse lands between ticks
		else if (tick)
		begin
			if (bullet.active)
			begin
				if (step_ok(bullet.pos, bullet.dir))
					bullet.pos <= step_pos(bullet.pos, bullet.dir);
				else
					bullet.active <= 1'b0;  // would leave the grid
			end
			else if (cmd.fire)
			begin
				// launch from the pre-step cell and heading
				bullet <= '{active: 1'b1, pos: player_pos, dir: heading};
			end
		end
	end

	// bullet never shows up off the grid
	a_bullet_in_grid: assert property (@(posedge clk) disable iff (reset)
		bullet.active |-> (bullet.pos.x <= coord_t'(`TANK_X_MAX)) &&
			(bullet.pos.y <= coord_t'(`TANK_Y_MAX)))
		else $error("bullet left the grid");

endmodule

`default_nettype wire

/* enemy/enemy_relpos.sv */
// registered distance and relative direction from one enemy to the player
`default_nettype none
`timescale 1ns/100ps

module enemy_relpos
	import tank_geom_pkg::*;
(
	input  logic    clk,
	input  logic    reset,
	input  pos_t    enemy_pos,
	input  pos_t    player_pos,
	output relpos_t relpos
);

	coord_t   h_dis;
	coord_t   v_dis;
	rel_dir_u rel;

	// ------------------------------
	// distances and direction word
	// ------------------------------
	always_comb
	begin
		// absolute differences without sign
		h_dis = (enemy_pos.x > player_pos.x) ? enemy_pos.x - player_pos.x
			: player_pos.x - enemy_pos.x;
		v_dis = (enemy_pos.y > player_pos.y) ? enemy_pos.y - player_pos.y
			: player_pos.y - enemy_pos.y;

		rel = '0;
		if (h_dis != '0 && v_dis != '0)
		begin
			// quadrant form when off both axes
			rel.quad.is_line = 1'b0;
			rel.quad.left    = enemy_pos.x < player_pos.x;
			rel.quad.above   = enemy_pos.y < player_pos.y;
		end
		else
		begin
			// line form on a shared row or column
			rel.line.is_line = 1'b1;
			rel.line.vert    = (h_dis == '0);
			rel.line.far     = (h_dis == '0) ? (enemy_pos.y > player_pos.y)
				: (enemy_pos.x > player_pos.x);
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			relpos <= '0;
		else
			relpos <= '{rel: rel, h_dis: h_dis, v_dis: v_dis,
				equal: (h_dis == '0) && (v_dis == '0)};
	end

	// line form only when the tanks really shared an axis one cycle back
	a_line_aligned: assert property (@(posedge clk) disable iff (reset)
		relpos.rel.line.is_line |->
			($past(enemy_pos.x) == $past(player_pos.x)) ||
			($past(enemy_pos.y) == $past(player_pos.y)))
		else $error("line form while the tanks share no axis");

endmodule

`default_nettype wire

/* enemy/enemy_tank.sv */
// enemy tank spawn, pursuit step, fire flag and hit detection
`default_nettype none
`timescale 1ns/100ps

`include "tank_params.svh"

module enemy_tank
	import tank_geom_pkg::*, tank_ctrl_pkg::*;
#(
	parameter int SPAWN_ID = 0  // corner select, bit 0 right, bit 1 bottom
)(
	input  logic          clk,
	input  logic          reset,
	input  logic          tick,
	input  logic          enable,      // may spawn when dead
	input  pos_t          player_pos,
	input  bullet_t       bullet,
	output enemy_status_t status,
	output logic          kill         // one cycle, after the hit tick
);

	localparam coord_t    SPAWN_X   = (SPAWN_ID % 2 != 0) ? coord_t'(`TANK_X_MAX) : '0;
	localparam coord_t    SPAWN_Y   = (SPAWN_ID / 2 != 0) ? coord_t'(`TANK_Y_MAX) : '0;
	localparam tank_dir_t SPAWN_DIR = (SPAWN_ID / 2 != 0) ? DIR_UP : DIR_DOWN;  // face inward

	relpos_t   rp;      // one cycle behind the positions
	logic      hit;
	tank_dir_t mv_dir;  // chosen pursuit heading

	enemy_relpos i_enemy_relpos (
		.clk        (clk),
		.reset      (reset),
		.enemy_pos  (status.pos),
		.player_pos (player_pos),
		.relpos     (rp)
	);

	// ------------------------------
	// hit and pursuit decision
	// ------------------------------
	always_comb
	begin
		hit = status.alive &&
			((bullet.active && bullet.pos == status.pos) || player_pos == status.pos);

		if (rp.rel.line.is_line)
		begin
			// lined up, close in along the line
			if (rp.rel.line.vert)
				mv_dir = rp.rel.line.far ? DIR_UP : DIR_DOWN;
			else
				mv_dir = rp.rel.line.far ? DIR_LEFT : DIR_RIGHT;
		end
		else if (rp.h_dis < rp.v_dis)
			mv_dir = rp.rel.quad.left ? DIR_RIGHT : DIR_LEFT;  // shorter gap first
		else
			mv_dir = rp.rel.quad.above ? DIR_DOWN : DIR_UP;
	end

	// ------------------------------
	// per-step state
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			status <= '0;  // dead, fire low
			kill   <= 1'b0;
		end
		else
		begin
			kill <= 1'b0;
			if (tick)
			begin
				if (!status.alive)
				begin
					if (enable)
						status <= '{alive: 1'b1, pos: '{x: SPAWN_X, y: SPAWN_Y},
							dir: SPAWN_DIR, fire: 1'b0};
				end
				else if (hit)
				begin
					// hit wins over movement
					status.alive <= 1'b0;
					status.fire  <= 1'b0;
					kill         <= 1'b1;
				end
				else if (!rp.equal)
				begin
					status.dir  <= mv_dir;              // recorded even if blocked
					status.fire <= rp.rel.line.is_line;  // lined up on a row or column
					if (step_ok(status.pos, mv_dir))
						status.pos <= step_pos(status.pos, mv_dir);
				end
			end
		end
	end

	// live enemy stays on the field
	a_enemy_in_grid: assert property (@(posedge clk) disable iff (reset)
		status.alive |-> (status.pos.x <= coord_t'(`TANK_X_MAX)) &&
			(status.pos.y <= coord_t'(`TANK_Y_MAX)))
		else $error("alive enemy outside the grid");

endmodule

`default_nettype wire

/* logic/arena_status.sv */
// kill counter, alive mask and game-over latch
`default_nettype none
`timescale 1ns/100ps

`include "tank_params.svh"

module arena_status
	import tank_geom_pkg::*, tank_ctrl_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  enemy_status_t [`TANK_ENEMY_CNT-1:0] enemy,
	input  logic          [`TANK_ENEMY_CNT-1:0] kill,
	input  pos_t                                 player_pos,
	output logic          [`TANK_KILL_W-1:0]    kill_count,
	output logic          [`TANK_ENEMY_CNT-1:0] alive_mask,
	output logic                                 game_over
);

	localparam int ADD_W = $clog2(`TANK_ENEMY_CNT + 1);  // room for all kills at once
	localparam int SUM_W = `TANK_KILL_W + 1;             // carry marks overflow

	logic [ADD_W-1:0] kill_add;
	logic [SUM_W-1:0] kill_sum;
	logic             on_player;  // some live enemy on the player's cell

	always_comb
	begin
		kill_add  = '0;
		on_player = 1'b0;
		for (int i = 0; i < `TANK_ENEMY_CNT; i++)
		begin
			kill_add      = kill_add + ADD_W'(kill[i]);
			alive_mask[i] = enemy[i].alive;
			on_player     = on_player || (enemy[i].alive && enemy[i].pos == player_pos);
		end
		kill_sum = {1'b0, kill_count} + SUM_W'(kill_add);
	end

	// ------------------------------
	// counter and latch
	// ------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			kill_count <= '0;
			game_over  <= 1'b0;
		end
		else
		begin
			if (kill_sum[`TANK_KILL_W])
				kill_count <= '1;  // saturate
			else
				kill_count <= kill_sum[`TANK_KILL_W-1:0];
			if (on_player)
				game_over <= 1'b1;  // sticky until reset
		end
	end

	a_kills_monotonic: assert property (@(posedge clk) disable iff (reset)
		!$past(reset) |-> kill_count >= $past(kill_count))
		else $error("kill count went down");

endmodule

`default_nettype wire

/* logic/tank_arena_top.sv */
// top level joining player tank, four enemy tanks and the status block
`default_nettype none
`timescale 1ns/100ps

`include "tank_params.svh"

module tank_arena_top
	import tank_geom_pkg::*, tank_ctrl_pkg::*;
(
	input  logic                                 clk,
	input  logic                                 reset,
	input  logic                                 tick,      // game step strobe
	input  player_cmd_t                          cmd,
	input  logic          [`TANK_ENEMY_CNT-1:0] enemy_en,
	output pos_t                                 player_pos,
	output bullet_t                              bullet,
	output enemy_status_t [`TANK_ENEMY_CNT-1:0] enemy,
	output logic          [`TANK_KILL_W-1:0]    kill_count,
	output logic          [`TANK_ENEMY_CNT-1:0] alive_mask,
	output logic                                 game_over
);

	logic [`TANK_ENEMY_CNT-1:0] kill;  // per-enemy death pulses

	// ------------------------------
	// input side
	// ------------------------------
	player_tank i_player_tank (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.cmd        (cmd),
		.bullet_hit (|kill),  // any kill retires the bullet
		.player_pos (player_pos),
		.bullet     (bullet)
	);

	// ------------------------------
	// enemies, one per corner
	// ------------------------------
	for (genvar i = 0; i < `TANK_ENEMY_CNT; i++)
	begin : g_enemy
		enemy_tank #(.SPAWN_ID(i)) i_enemy_tank (
			.clk        (clk),
			.reset      (reset),
			.tick       (tick),
			.enable     (enemy_en[i]),
			.player_pos (player_pos),
			.bullet     (bullet),
			.status     (enemy[i]),
			.kill       (kill[i])
		);
	end

	arena_status i_arena_status (
		.clk        (clk),
		.reset      (reset),
		.enemy      (enemy),
		.kill       (kill),
		.player_pos (player_pos),
		.kill_count (kill_count),
		.alive_mask (alive_mask),
		.game_over  (game_over)
	);

endmodule

`default_nettype wire

/* dv/tank_arena_tb.sv */
// testbench with clock, reset, pattern replay, compare tasks and summary
`default_nettype none
`timescale 1ns/100ps

`include "tank_params.svh"

module tank_arena_tb
	import tank_geom_pkg::*, tank_ctrl_pkg::*;
;

	localparam int    STEP_CNT     = 19;   // data lines in the pattern file
	localparam int    LINE_W       = 172;  // 43 hex digits per line
	localparam int    WAIT_LIMIT   = 20;   // cycles allowed for any wait loop
	localparam string PATTERN_FILE = "dv/tank_arena_patterns.txt";

	logic                                 clk;
	logic                                 reset;
	logic                                 tick;
	player_cmd_t                          cmd;
	logic          [`TANK_ENEMY_CNT-1:0] enemy_en;
	pos_t                                 player_pos;
	bullet_t                              bullet;
	enemy_status_t [`TANK_ENEMY_CNT-1:0] enemy;
	logic          [`TANK_KILL_W-1:0]    kill_count;
	logic          [`TANK_ENEMY_CNT-1:0] alive_mask;
	logic                                 game_over;

	logic [LINE_W-1:0] patterns [0:STEP_CNT-1];
	int                value_errs;
	int                timeout_errs;
	int                step;

	tank_arena_top i_tank_arena_top (
		.clk        (clk),
		.reset      (reset),
		.tick       (tick),
		.cmd        (cmd),
		.enemy_en   (enemy_en),
		.player_pos (player_pos),
		.bullet     (bullet),
		.enemy      (enemy),
		.kill_count (kill_count),
		.alive_mask (alive_mask),
		.game_over  (game_over)
	);

	always #5 clk = ~clk;  // 10 ns period

	// ------------------------------
	// field decode
	// ------------------------------
	function automatic enemy_status_t slot_to_enemy(input logic [27:0] s);
		enemy_status_t e;
		e.alive = s[24];
		e.pos.x = s[20:16];         // low bits of the x byte
		e.pos.y = s[12:8];
		e.dir   = tank_dir_t'(s[5:4]);
		e.fire  = s[0];
		return e;
	endfunction

	function automatic enemy_status_t line_enemy(input logic [LINE_W-1:0] w, input int idx);
		logic [27:0] s;
		s = w[123 - 28*idx -: 28];  // enemy 0 sits highest
		return slot_to_enemy(s);
	endfunction

	// readable forms for the error lines
	function automatic string bullet_text(input bullet_t b);
		return $sformatf("active %0b at (%0d,%0d) dir %0d",
			b.active, b.pos.x, b.pos.y, b.dir);
	endfunction

	function automatic string enemy_text(input enemy_status_t e);
		return $sformatf("alive %0b at (%0d,%0d) dir %0d fire %0b",
			e.alive, e.pos.x, e.pos.y, e.dir, e.fire);
	endfunction

	// ------------------------------
	// compare tasks
	// ------------------------------
	task automatic check_pos(input string name, input pos_t exp, input pos_t act);
		if (act !== exp)
		begin
			value_errs++;
			$display("CHECK FAILED %s: expected (%0d,%0d) actual (%0d,%0d)",
				name, exp.x, exp.y, act.x, act.y);
		end
	endtask

	task automatic check_bullet(input string name, input bullet_t exp, input bullet_t act);
		if (act !== exp)
		begin
			value_errs++;
			$display("CHECK FAILED %s: expected %s actual %s",
				name, bullet_text(exp), bullet_text(act));
		end
	endtask

	task automatic check_enemy(input string name, input enemy_status_t exp,
		input enemy_status_t act);
		if (act !== exp)
		begin
			value_errs++;
			$display("CHECK FAILED %s: expected %s actual %s",
				name, enemy_text(exp), enemy_text(act));
		end
	endtask

	task automatic check_count(input string name, input logic [`TANK_KILL_W-1:0] exp,
		input logic [`TANK_KILL_W-1:0] act);
		if (act !== exp)
		begin
			value_errs++;
			$display("CHECK FAILED %s: expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			value_errs++;
			$display("CHECK FAILED %s: expected %0b actual %0b", name, exp, act);
		end
	endtask

	// ------------------------------
	// sequencing
	// ------------------------------
	task automatic next_edge();
		@(posedge clk);
		#1;  // drive and sample just past the edge
	endtask

	task automatic wait_reset_done();
		int   n;
		pos_t start;
		n       = 0;
		start.x = 5'd8;   // bottom middle
		start.y = 5'd20;
		while (!(player_pos == start && kill_count == '0 && !game_over) && n < WAIT_LIMIT)
		begin
			next_edge();
			n++;
		end
		if (n >= WAIT_LIMIT)
		begin
			timeout_errs++;
			$display("timeout: DUT never showed its reset state");
		end
	endtask

	task automatic run_step(input int idx);
		logic [LINE_W-1:0] w;
		bullet_t           exp_b;
		enemy_status_t     exp_e;
		pos_t              exp_p;
		w = patterns[idx];
		cmd      = player_cmd_t'(w[171:168]);
		enemy_en = w[167:164];
		tick     = 1'b1;
		next_edge();
		tick = 1'b0;
		repeat (3) next_edge();  // relpos and status settle

		exp_p.x = w[160:156];
		exp_p.y = w[152:148];
		check_pos($sformatf("step %0d player_pos", idx), exp_p, player_pos);
		exp_b.active = w[144];
		exp_b.pos.x  = w[140:136];
		exp_b.pos.y  = w[132:128];
		exp_b.dir    = tank_dir_t'(w[125:124]);
		check_bullet($sformatf("step %0d bullet", idx), exp_b, bullet);
		for (int i = 0; i < `TANK_ENEMY_CNT; i++)
		begin
			exp_e = line_enemy(w, i);
			check_enemy($sformatf("step %0d enemy %0d", idx, i), exp_e, enemy[i]);
			check_flag($sformatf("step %0d alive_mask[%0d]", idx, i), exp_e.alive,
				alive_mask[i]);
		end
		check_count($sformatf("step %0d kill_count", idx), w[11:4], kill_count);
		check_flag($sformatf("step %0d game_over", idx), w[0], game_over);
	endtask

	// last alive mask must hold with no tick pending
	task automatic drain();
		int                         n;
		logic [`TANK_ENEMY_CNT-1:0] exp_mask;
		enemy_status_t              e;
		n = 0;
		for (int i = 0; i < `TANK_ENEMY_CNT; i++)
		begin
			e           = line_enemy(patterns[STEP_CNT-1], i);
			exp_mask[i] = e.alive;
		end
		while (alive_mask !== exp_mask && n < WAIT_LIMIT)
		begin
			next_edge();
			n++;
		end
		if (n >= WAIT_LIMIT)
		begin
			timeout_errs++;
			$display("timeout: alive mask did not settle after the last step");
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		clk          = 1'b0;
		reset        = 1'b1;
		tick         = 1'b0;
		cmd          = '0;
		enemy_en     = '0;
		value_errs   = 0;
		timeout_errs = 0;
		$readmemh(PATTERN_FILE, patterns);

		repeat (5) @(posedge clk);  // reset for 5 cycles
		#1;
		reset = 1'b0;
		wait_reset_done();

		for (step = 0; step < STEP_CNT; step++)
			run_step(step);
		drain();

		$display("errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
		if (value_errs == 0 && timeout_errs == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* tank_arena.f */
+incdir+common
common/tank_geom_pkg.sv
common/tank_ctrl_pkg.sv
logic/player_tank.sv
enemy/enemy_relpos.sv
enemy/enemy_tank.sv
logic/arena_status.sv
logic/tank_arena_top.sv
dv/tank_arena_tb.sv

/* Makefile */
# Verilator lint and simulation for tank_arena

VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = tank_arena_top
TB_TOP    = tank_arena_tb
FILELIST  = tank_arena.f
OBJ_DIR   = obj_dir
SIM_BIN   = tank_arena_sim
LOG       = sim.log
PASS_MSG  = *** TEST PASSED ***

.PHONY: all lint sim clean

all: lint sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --binary --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/tank_arena_patterns.txt */
// cmd en _ player x y _ bullet act x y dir _ enemy 0..3 (alive x y dir fire) _ kills _ game over
// cmd nibble is {move, dir[1:0], fire}, all fields after the inputs are expected values
E8_0914_000000_0000000_0000000_0000000_1101400_00_0
18_0914_109143_0000000_0000000_0000000_10f1421_00_0
10_0914_10a143_0000000_0000000_0000000_10e1421_00_0
00_0914_10b143_0000000_0000000_0000000_10d1421_00_0
00_0914_10c143_0000000_0000000_0000000_10c1421_00_0
00_0914_00d143_0000000_0000000_0000000_00c1420_01_0
08_0914_00d143_0000000_0000000_0000000_1101400_01_0
A9_0914_00d143_1000010_0000000_0000000_10f1421_01_0
10_0914_109141_1010030_0000000_0000000_10e1421_01_0
00_0914_009141_1020030_0000000_0000000_10d1421_01_0
80_0913_009141_1030030_0000000_0000000_10c1421_01_0
00_0913_009141_1040030_0000000_0000000_10c1300_01_0
00_0913_009141_1050030_0000000_0000000_10b1321_01_0
00_0913_009141_1060030_0000000_0000000_10a1321_01_0
00_0913_009141_1070030_0000000_0000000_1091321_01_1
00_0913_009141_1080030_0000000_0000000_0091320_02_1
00_0913_009141_1090030_0000000_0000000_0091320_02_1
00_0913_009141_1090111_0000000_0000000_0091320_02_1
00_0913_009141_1090211_0000000_0000000_0091320_02_1
